/* design/alu.sv */
`default_nettype none

module alu (
    input  logic [1:0]  alu_op_i,
    input  logic [2:0]  funct3_i,
    input  logic        funct7b5_i,
    input  logic        is_op_i,    // Register form where bit 30 means SUB
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic [31:0] result_o,
    output logic        zero_o,
    output logic        lt_o,
    output logic        ltu_o
);

    logic [4:0]  shamt;
    logic [31:0] sra_res;

    assign shamt   = b_i[4:0];
    assign sra_res = $signed(a_i) >>> shamt;  // Sign bit fills from the left

    // Flags come straight from the operands
    assign zero_o = (a_i == b_i);
    assign lt_o   = ($signed(a_i) < $signed(b_i));
    assign ltu_o  = (a_i < b_i);

    always_comb begin
        case (alu_op_i)
            riscv_pkg::ALUOP_ADD:    result_o = a_i + b_i;
            riscv_pkg::ALUOP_BRANCH: result_o = a_i - b_i;
            riscv_pkg::ALUOP_PASS_B: result_o = b_i;  // LUI
            default: begin
                case (funct3_i)
                    3'b000: result_o = (is_op_i && funct7b5_i) ? a_i - b_i : a_i + b_i;
                    3'b001: result_o = a_i << shamt;
                    3'b010: result_o = {31'b0, lt_o};
                    3'b011: result_o = {31'b0, ltu_o};
                    3'b100: result_o = a_i ^ b_i;
                    3'b101: result_o = funct7b5_i ? sra_res : a_i >> shamt;
                    3'b110: result_o = a_i | b_i;
                    default: result_o = a_i & b_i;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/main_decoder.sv */
`default_nettype none

module main_decoder (
    input  logic [6:0] opcode_i,
    input  logic [2:0] funct3_i,
    output logic       reg_wr_en_o,
    output logic       mem_wr_en_o,
    output logic [2:0] imm_src_o,
    output logic       alu_src_o,    // 1 selects the immediate
    output logic       alu_a_src_o,  // 1 selects the PC
    output logic       branch_o,
    output logic       jump_o,
    output logic [1:0] result_src_o,
    output logic [1:0] alu_op_o,
    output logic [3:0] byte_en_o,
    output logic       illegal_o
);

    logic [3:0] size_be;

    // Access width from funct3, unsigned variants share the signed width
    always_comb begin
        case (funct3_i[1:0])
            2'b00:   size_be = 4'b0001;
            2'b01:   size_be = 4'b0011;
            default: size_be = 4'b1111;
        endcase
    end

    always_comb begin
        reg_wr_en_o  = 1'b0;
        mem_wr_en_o  = 1'b0;
        imm_src_o    = riscv_pkg::IMM_I;
        alu_src_o    = 1'b0;
        alu_a_src_o  = 1'b0;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        result_src_o = riscv_pkg::RES_ALU;
        alu_op_o     = riscv_pkg::ALUOP_ADD;
        byte_en_o    = 4'b0000;
        illegal_o    = 1'b0;

        case (opcode_i)
            riscv_pkg::OPC_LOAD: begin
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = riscv_pkg::RES_MEM;
                byte_en_o    = size_be;
            end
            riscv_pkg::OPC_OP_IMM: begin
                reg_wr_en_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = riscv_pkg::ALUOP_FUNCT;
                if (funct3_i[1:0] == 2'b01) begin
                    imm_src_o = riscv_pkg::IMM_SHAMT;  // SLLI, SRLI, SRAI
                end
            end
            riscv_pkg::OPC_STORE: begin
                mem_wr_en_o = 1'b1;
                imm_src_o   = riscv_pkg::IMM_S;
                alu_src_o   = 1'b1;
                byte_en_o   = size_be;
            end
            riscv_pkg::OPC_OP: begin
                reg_wr_en_o = 1'b1;
                alu_op_o    = riscv_pkg::ALUOP_FUNCT;
            end
            riscv_pkg::OPC_BRANCH: begin
                imm_src_o = riscv_pkg::IMM_B;
                branch_o  = 1'b1;
                alu_op_o  = riscv_pkg::ALUOP_BRANCH;
            end
            riscv_pkg::OPC_JAL: begin
                reg_wr_en_o  = 1'b1;
                imm_src_o    = riscv_pkg::IMM_J;
                alu_src_o    = 1'b1;
                alu_a_src_o  = 1'b1;  // Target is PC + offset
                jump_o       = 1'b1;
                result_src_o = riscv_pkg::RES_PC4;
            end
            riscv_pkg::OPC_JALR: begin
                reg_wr_en_o  = 1'b1;
                alu_src_o    = 1'b1;
                jump_o       = 1'b1;
                result_src_o = riscv_pkg::RES_PC4;
            end
            riscv_pkg::OPC_LUI: begin
                reg_wr_en_o = 1'b1;
                imm_src_o   = riscv_pkg::IMM_U;
                alu_src_o   = 1'b1;
                alu_op_o    = riscv_pkg::ALUOP_PASS_B;
            end
            riscv_pkg::OPC_AUIPC: begin
                reg_wr_en_o = 1'b1;
                imm_src_o   = riscv_pkg::IMM_U;
                alu_src_o   = 1'b1;
                alu_a_src_o = 1'b1;
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`default_nettype none

module mem_arbiter (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic [2:0]      req_i,
    input  logic [2:0]      we_i,
    input  logic [2:0][3:0] be_i,
    input  logic [2:0][31:0] addr_i,
    input  logic [2:0][31:0] wdata_i,
    output logic [2:0]      gnt_o,
    output logic [2:0]      rvalid_o,
    output logic [31:0]     rdata_o,
    output logic            mem_en_o,
    output logic            mem_we_o,
    output logic [3:0]      mem_be_o,
    output logic [7:0]      mem_idx_o,
    output logic [31:0]     mem_wdata_o,
    input  logic [31:0]     mem_rdata_i
);

    logic [1:0] sel;
    logic [2:0] rd_pend_q;  // Read granted last cycle, one bit per requester

    // Fixed priority, loader first and fetch last
    always_comb begin
        gnt_o = 3'b000;
        sel   = 2'(riscv_pkg::REQ_FETCH);
        if (req_i[riscv_pkg::REQ_LOADER]) begin
            gnt_o[riscv_pkg::REQ_LOADER] = 1'b1;
            sel = 2'(riscv_pkg::REQ_LOADER);
        end else if (req_i[riscv_pkg::REQ_DATA]) begin
            gnt_o[riscv_pkg::REQ_DATA] = 1'b1;
            sel = 2'(riscv_pkg::REQ_DATA);
        end else if (req_i[riscv_pkg::REQ_FETCH]) begin
            gnt_o[riscv_pkg::REQ_FETCH] = 1'b1;
        end
    end

    assign mem_en_o    = |req_i;
    assign mem_we_o    = we_i[sel];
    assign mem_be_o    = be_i[sel];
    assign mem_idx_o   = addr_i[sel][riscv_pkg::MEM_AW+1:2];  // Byte to word address
    assign mem_wdata_o = wdata_i[sel];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_pend_q <= 3'b000;
        end else begin
            rd_pend_q <= gnt_o & ~we_i;
        end
    end

    assign rvalid_o = rd_pend_q;
    assign rdata_o  = mem_rdata_i;  // Shared, qualified by rvalid

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o));

endmodule

`default_nettype wire

/* design/reg_file.sv */
`default_nettype none

module reg_file (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    input  logic [4:0]  rd_i,
    input  logic        we_i,
    input  logic [31:0] wd_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);

    logic [riscv_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != 5'd0) begin
            regs[rd_i] <= wd_i;
        end
    end

    // x0 is never written, so it stays zero after reset
    assign rd1_o = regs[rs1_i];
    assign rd2_o = regs[rs2_i];

endmodule

`default_nettype wire

/* design/riscv_core.sv */
`default_nettype none

module riscv_core (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        run_i,
    output logic        if_req_o,
    output logic [31:0] if_addr_o,
    input  logic        if_gnt_i,
    input  logic        if_rvalid_i,
    input  logic [31:0] if_rdata_i,
    output logic        dm_req_o,
    output logic        dm_we_o,
    output logic [3:0]  dm_be_o,
    output logic [31:0] dm_addr_o,
    output logic [31:0] dm_wdata_o,
    input  logic        dm_gnt_i,
    input  logic        dm_rvalid_i,
    input  logic [31:0] dm_rdata_i,
    output logic        retire_o,
    output logic [31:0] retire_pc_o,
    output logic        rd_wr_o,
    output logic [4:0]  rd_addr_o,
    output logic [31:0] rd_data_o,
    output logic        halted_o
);

    typedef enum logic [2:0] {IDLE, FETCH, FWAIT, EXEC, MEM, MWAIT, HALT} state_t;

    state_t      state_q;
    logic [31:0] pc_q, instr_q, imm, rs1_val, rs2_val, alu_a, alu_b, alu_res;
    logic [31:0] pc_plus4, next_pc, load_sh, load_data, wb_data;
    logic        reg_wr_en, mem_wr_en, alu_src, alu_a_src, branch, jump, illegal;
    logic        zero, lt, ltu, taken, is_load;
    logic [2:0]  imm_src, funct3;
    logic [1:0]  result_src, alu_op;
    logic [3:0]  byte_en;

    assign funct3 = instr_q[14:12];

    main_decoder u_dec (
        .opcode_i(instr_q[6:0]), .funct3_i(funct3),
        .reg_wr_en_o(reg_wr_en), .mem_wr_en_o(mem_wr_en), .imm_src_o(imm_src),
        .alu_src_o(alu_src), .alu_a_src_o(alu_a_src), .branch_o(branch), .jump_o(jump),
        .result_src_o(result_src), .alu_op_o(alu_op), .byte_en_o(byte_en),
        .illegal_o(illegal)
    );

    reg_file u_rf (
        .clk_i, .reset_i, .rs1_i(instr_q[19:15]), .rs2_i(instr_q[24:20]),
        .rd_i(instr_q[11:7]), .we_i(rd_wr_o), .wd_i(wb_data),
        .rd1_o(rs1_val), .rd2_o(rs2_val)
    );

    always_comb begin
        case (imm_src)
            riscv_pkg::IMM_S: imm = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
            riscv_pkg::IMM_B: imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                                     instr_q[30:25], instr_q[11:8], 1'b0};
            riscv_pkg::IMM_U: imm = {instr_q[31:12], 12'b0};
            riscv_pkg::IMM_J: imm = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                                     instr_q[20], instr_q[30:21], 1'b0};
            riscv_pkg::IMM_SHAMT: imm = {27'b0, instr_q[24:20]};
            default: imm = {{20{instr_q[31]}}, instr_q[31:20]};
        endcase
    end

    assign alu_a = alu_a_src ? pc_q : rs1_val;
    assign alu_b = alu_src ? imm : rs2_val;

    alu u_alu (
        .alu_op_i(alu_op), .funct3_i(funct3), .funct7b5_i(instr_q[30]),
        .is_op_i(instr_q[6:0] == riscv_pkg::OPC_OP), .a_i(alu_a), .b_i(alu_b),
        .result_o(alu_res), .zero_o(zero), .lt_o(lt), .ltu_o(ltu)
    );

    // BEQ BNE, BLT BGE, BLTU BGEU, bit 0 inverts
    always_comb begin
        case (funct3[2:1])
            2'b00:   taken = zero ^ funct3[0];
            2'b10:   taken = lt ^ funct3[0];
            default: taken = ltu ^ funct3[0];
        endcase
    end

    assign pc_plus4 = pc_q + 32'd4;
    assign next_pc  = jump ? {alu_res[31:1], 1'b0} :
                      (branch && taken) ? pc_q + imm : pc_plus4;

    assign is_load    = (result_src == riscv_pkg::RES_MEM);
    assign dm_addr_o  = alu_res;  // Operands stay stable through MEM and MWAIT
    assign dm_req_o   = (state_q == MEM);
    assign dm_we_o    = mem_wr_en;
    assign dm_be_o    = byte_en << dm_addr_o[1:0];
    assign dm_wdata_o = rs2_val << {dm_addr_o[1:0], 3'b000};

    assign load_sh = dm_rdata_i >> {dm_addr_o[1:0], 3'b000};
    always_comb begin
        case (funct3)
            3'b000:  load_data = {{24{load_sh[7]}}, load_sh[7:0]};    // LB
            3'b001:  load_data = {{16{load_sh[15]}}, load_sh[15:0]};  // LH
            3'b100:  load_data = {24'b0, load_sh[7:0]};               // LBU
            3'b101:  load_data = {16'b0, load_sh[15:0]};              // LHU
            default: load_data = load_sh;
        endcase
    end

    always_comb begin
        case (result_src)
            riscv_pkg::RES_MEM: wb_data = load_data;
            riscv_pkg::RES_PC4: wb_data = pc_plus4;
            default:            wb_data = alu_res;
        endcase
    end

    assign if_req_o  = (state_q == FETCH);
    assign if_addr_o = pc_q;
    assign halted_o  = (state_q == HALT);

    assign retire_o = (state_q == EXEC && !illegal && !is_load && !mem_wr_en) ||
                      (state_q == MEM && dm_gnt_i && mem_wr_en) ||
                      (state_q == MWAIT && dm_rvalid_i);
    assign retire_pc_o = pc_q;
    assign rd_addr_o   = instr_q[11:7];
    assign rd_wr_o     = retire_o && reg_wr_en && (instr_q[11:7] != 5'd0);
    assign rd_data_o   = wb_data;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            pc_q    <= '0;
        end else begin
            if (retire_o) begin
                pc_q <= next_pc;
            end
            case (state_q)
                IDLE:  if (run_i) state_q <= FETCH;
                FETCH: if (if_gnt_i) state_q <= FWAIT;
                FWAIT: if (if_rvalid_i) state_q <= EXEC;
                EXEC:  state_q <= illegal ? HALT : (is_load || mem_wr_en) ? MEM : FETCH;
                MEM:   if (dm_gnt_i) state_q <= mem_wr_en ? FETCH : MWAIT;
                MWAIT: if (dm_rvalid_i) state_q <= FETCH;
                default: state_q <= HALT;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FWAIT && if_rvalid_i) begin
            instr_q <= if_rdata_i;
        end
    end

    a_no_retire_in_reset: assert property (@(posedge clk_i) reset_i |-> !retire_o);
    a_dm_be_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
        dm_req_o |-> dm_be_o != 4'b0000);

endmodule

`default_nettype wire

/* design/riscv_mini_top.sv */
`default_nettype none

module riscv_mini_top (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        run_i,
    input  logic        load_req_i,
    input  logic [31:0] load_addr_i,
    input  logic [31:0] load_data_i,
    output logic        load_gnt_o,
    output logic        retire_o,
    output logic [31:0] retire_pc_o,
    output logic        rd_wr_o,
    output logic [4:0]  rd_addr_o,
    output logic [31:0] rd_data_o,
    output logic        halted_o
);

    logic [2:0]                        req, we, gnt, rvalid;
    logic [2:0][3:0]                   be;
    logic [2:0][riscv_pkg::XLEN-1:0]   addr, wdata;
    logic [31:0]                       rdata, mem_wdata, mem_rdata;
    logic                              mem_en, mem_we;
    logic [3:0]                        mem_be;
    logic [7:0]                        mem_idx;

    // Loader slot only writes whole words
    assign req[riscv_pkg::REQ_LOADER]   = load_req_i;
    assign we[riscv_pkg::REQ_LOADER]    = 1'b1;
    assign be[riscv_pkg::REQ_LOADER]    = 4'b1111;
    assign addr[riscv_pkg::REQ_LOADER]  = load_addr_i;
    assign wdata[riscv_pkg::REQ_LOADER] = load_data_i;
    assign load_gnt_o = gnt[riscv_pkg::REQ_LOADER];

    // Fetch port never writes
    assign we[riscv_pkg::REQ_FETCH]    = 1'b0;
    assign be[riscv_pkg::REQ_FETCH]    = 4'b1111;
    assign wdata[riscv_pkg::REQ_FETCH] = '0;

    riscv_core u_core (
        .clk_i, .reset_i, .run_i,
        .if_req_o(req[riscv_pkg::REQ_FETCH]), .if_addr_o(addr[riscv_pkg::REQ_FETCH]),
        .if_gnt_i(gnt[riscv_pkg::REQ_FETCH]), .if_rvalid_i(rvalid[riscv_pkg::REQ_FETCH]),
        .if_rdata_i(rdata),
        .dm_req_o(req[riscv_pkg::REQ_DATA]), .dm_we_o(we[riscv_pkg::REQ_DATA]),
        .dm_be_o(be[riscv_pkg::REQ_DATA]), .dm_addr_o(addr[riscv_pkg::REQ_DATA]),
        .dm_wdata_o(wdata[riscv_pkg::REQ_DATA]), .dm_gnt_i(gnt[riscv_pkg::REQ_DATA]),
        .dm_rvalid_i(rvalid[riscv_pkg::REQ_DATA]), .dm_rdata_i(rdata),
        .retire_o, .retire_pc_o, .rd_wr_o, .rd_addr_o, .rd_data_o, .halted_o
    );

    mem_arbiter u_arb (
        .clk_i, .reset_i, .req_i(req), .we_i(we), .be_i(be), .addr_i(addr),
        .wdata_i(wdata), .gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(rdata),
        .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_be_o(mem_be), .mem_idx_o(mem_idx),
        .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata)
    );

    unified_mem u_mem (
        .clk_i, .en_i(mem_en), .we_i(mem_we), .be_i(mem_be), .idx_i(mem_idx),
        .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

/* design/riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    localparam int XLEN      = 32;
    localparam int MEM_WORDS = 256;  // 1 KiB unified memory
    localparam int MEM_AW    = 8;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // Immediate formats
    localparam logic [2:0] IMM_I     = 3'b000;
    localparam logic [2:0] IMM_S     = 3'b001;
    localparam logic [2:0] IMM_B     = 3'b010;
    localparam logic [2:0] IMM_U     = 3'b011;
    localparam logic [2:0] IMM_J     = 3'b100;
    localparam logic [2:0] IMM_SHAMT = 3'b101;

    localparam logic [1:0] ALUOP_ADD    = 2'b00;
    localparam logic [1:0] ALUOP_BRANCH = 2'b01;
    localparam logic [1:0] ALUOP_FUNCT  = 2'b10;
    localparam logic [1:0] ALUOP_PASS_B = 2'b11;

    // Write-back source
    localparam logic [1:0] RES_ALU = 2'b00;
    localparam logic [1:0] RES_MEM = 2'b01;
    localparam logic [1:0] RES_PC4 = 2'b10;

    // Arbiter slots, lowest index wins
    localparam int REQ_LOADER = 0;
    localparam int REQ_DATA   = 1;
    localparam int REQ_FETCH  = 2;

endpackage

`default_nettype wire

/* design/unified_mem.sv */
`default_nettype none

module unified_mem (
    input  logic        clk_i,
    input  logic        en_i,
    input  logic        we_i,
    input  logic [3:0]  be_i,
    input  logic [7:0]  idx_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] rdata_o
);

    logic [riscv_pkg::XLEN-1:0] mem [riscv_pkg::MEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read data one cycle after enable, old contents on a same-cycle write
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            rdata_o <= mem[idx_i];
        end
    end

    a_write_be: assert property (@(posedge clk_i) (en_i && we_i) |-> be_i != 4'b0000);

endmodule

`default_nettype wire

/* riscv_mini.f */
+incdir+tests
design/riscv_pkg.sv
design/main_decoder.sv
design/alu.sv
design/reg_file.sv
design/riscv_core.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/riscv_mini_top.sv
tests/riscv_mini_tb.sv

/* tests/riscv_mini_prog.svh */
`ifndef RISCV_MINI_PROG_SVH
`define RISCV_MINI_PROG_SVH

// Program image and one expected record per retired instruction
logic [31:0] prog [$];
logic [31:0] exp_pc [$];
logic        exp_wr [$];
logic [4:0]  exp_rd [$];
logic [31:0] exp_data [$];
logic [31:0] xr [32];  // Architectural register model
logic [31:0] seed;

function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
endfunction

function automatic logic [11:0] rand12();
    logic [31:0] r;
    r = lcg_next();
    return r[27:16];  // Upper bits have the longer period
endfunction

function automatic logic [31:0] sign_ext(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
                                       input logic [4:0] rd, rs1, rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, riscv_pkg::OPC_OP};
endfunction

function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] base, src,
                                       input logic [11:0] imm);
    return {imm[11:5], src, base, f3, imm[4:0], riscv_pkg::OPC_STORE};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::OPC_JAL};
endfunction

// RV32I integer result for OP and OP-IMM
function automatic logic [31:0] op_ref(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

task automatic emit(input logic [31:0] word, input logic wr, input logic [4:0] rd,
                    input logic [31:0] data);
    exp_pc.push_back(32'(prog.size() * 4));
    prog.push_back(word);
    exp_wr.push_back(wr && rd != 5'd0);
    exp_rd.push_back(rd);
    exp_data.push_back(data);
    if (wr && rd != 5'd0) begin
        xr[rd] = data;
    end
endtask

// Word that must never execute, sits in every skipped slot
task automatic put_filler();
    prog.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd31, 5'd0, 12'hfff));
endtask

task automatic add_branch(input logic [2:0] f3, input logic [4:0] a, b);
    logic tk;
    case (f3)
        3'b000:  tk = (xr[a] == xr[b]);
        3'b001:  tk = (xr[a] != xr[b]);
        3'b100:  tk = ($signed(xr[a]) < $signed(xr[b]));
        default: tk = (xr[a] >= xr[b]);  // BGEU
    endcase
    emit(b_type(f3, a, b, 13'd8), 1'b0, 5'd0, 32'd0);
    if (tk) begin
        put_filler();
    end
endtask

task automatic build_program();
    logic [31:0] v, m, pa;
    logic [11:0] imm;
    logic [19:0] hi;
    logic [3:0]  ops [10];  // {alt, funct3}
    seed = 32'd44;
    foreach (xr[r]) xr[r] = '0;
    ops = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    imm = rand12();
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd1, 5'd0, imm), 1'b1, 5'd1, sign_ext(imm));
    imm = rand12();
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd2, 5'd0, imm), 1'b1, 5'd2, sign_ext(imm));
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd0, 5'd1, 12'd5), 1'b1, 5'd0, 32'd0);
    for (int k = 0; k < 10; k++) begin
        emit(r_type(ops[k][2:0], ops[k][3], 5'(3 + k), 5'd1, 5'd2), 1'b1, 5'(3 + k),
             op_ref(ops[k][2:0], ops[k][3], xr[1], xr[2]));
        if (ops[k] != 4'h8) begin
            imm = rand12();
            if (ops[k][1:0] == 2'b01) begin
                imm = {1'b0, ops[k][3], 5'b0, imm[4:0]};  // Shift amount form
            end
            emit(i_type(riscv_pkg::OPC_OP_IMM, ops[k][2:0], 5'(13 + k), 5'd1, imm), 1'b1,
                 5'(13 + k), op_ref(ops[k][2:0], ops[k][3], xr[1], sign_ext(imm)));
        end
    end
    // Data word at 0x200, store values from LUI plus ADDI
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd20, 5'd0, 12'h200), 1'b1, 5'd20, 32'h200);
    v   = lcg_next();
    imm = v[11:0];
    hi  = 20'((v - sign_ext(imm)) >> 12);
    emit(u_type(riscv_pkg::OPC_LUI, 5'd21, hi), 1'b1, 5'd21, {hi, 12'b0});
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd21, 5'd21, imm), 1'b1, 5'd21,
         xr[21] + sign_ext(imm));
    imm = rand12();
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd22, 5'd0, imm), 1'b1, 5'd22, sign_ext(imm));
    imm = rand12();
    emit(i_type(riscv_pkg::OPC_OP_IMM, 3'b000, 5'd23, 5'd0, imm), 1'b1, 5'd23, sign_ext(imm));
    emit(s_type(3'b010, 5'd20, 5'd21, 12'd0), 1'b0, 5'd0, 32'd0);
    emit(s_type(3'b001, 5'd20, 5'd22, 12'd2), 1'b0, 5'd0, 32'd0);
    emit(s_type(3'b000, 5'd20, 5'd23, 12'd1), 1'b0, 5'd0, 32'd0);
    m = {xr[22][15:0], xr[21][15:0]};
    m[15:8] = xr[23][7:0];
    emit(i_type(riscv_pkg::OPC_LOAD, 3'b010, 5'd24, 5'd20, 12'd0), 1'b1, 5'd24, m);
    emit(i_type(riscv_pkg::OPC_LOAD, 3'b001, 5'd25, 5'd20, 12'd2), 1'b1, 5'd25,
         {{16{m[31]}}, m[31:16]});
    emit(i_type(riscv_pkg::OPC_LOAD, 3'b101, 5'd26, 5'd20, 12'd2), 1'b1, 5'd26,
         {16'b0, m[31:16]});
    emit(i_type(riscv_pkg::OPC_LOAD, 3'b000, 5'd27, 5'd20, 12'd1), 1'b1, 5'd27,
         {{24{m[15]}}, m[15:8]});
    emit(i_type(riscv_pkg::OPC_LOAD, 3'b100, 5'd28, 5'd20, 12'd3), 1'b1, 5'd28,
         {24'b0, m[31:24]});
    add_branch(3'b000, 5'd1, 5'd1);
    add_branch(3'b000, 5'd1, 5'd2);
    add_branch(3'b001, 5'd1, 5'd2);
    add_branch(3'b001, 5'd2, 5'd2);
    add_branch(3'b100, 5'd1, 5'd2);
    add_branch(3'b100, 5'd2, 5'd1);
    add_branch(3'b111, 5'd1, 5'd2);
    add_branch(3'b111, 5'd2, 5'd1);
    pa = 32'(prog.size() * 4);
    emit(j_type(5'd29, 21'd8), 1'b1, 5'd29, pa + 32'd4);
    put_filler();
    pa = 32'(prog.size() * 4);
    emit(u_type(riscv_pkg::OPC_AUIPC, 5'd19, 20'h00001), 1'b1, 5'd19, pa + 32'h1000);
    pa = 32'(prog.size() * 4);
    emit(u_type(riscv_pkg::OPC_AUIPC, 5'd30, 20'h00000), 1'b1, 5'd30, pa);
    // Odd offset 13 lands on pa + 12 once bit 0 is cleared
    emit(i_type(riscv_pkg::OPC_JALR, 3'b000, 5'd31, 5'd30, 12'd13), 1'b1, 5'd31, pa + 32'd8);
    put_filler();
    prog.push_back(32'h0000_0000);  // Illegal, halts the core
endtask

`endif

/* tests/riscv_mini_tb.sv */
`default_nettype none

module riscv_mini_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic        clk_i, reset_i, run_i;
    logic        load_req_i, load_gnt_o;
    logic [31:0] load_addr_i, load_data_i;
    logic        retire_o, rd_wr_o, halted_o;
    logic [31:0] retire_pc_o, rd_data_o;
    logic [4:0]  rd_addr_o;
    int          errors, checks, retire_cnt;
    bit          built;

    `include "riscv_mini_prog.svh"

    riscv_mini_top dut (
        .clk_i(clk_i), .reset_i(reset_i), .run_i(run_i),
        .load_req_i(load_req_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
        .load_gnt_o(load_gnt_o), .retire_o(retire_o), .retire_pc_o(retire_pc_o),
        .rd_wr_o(rd_wr_o), .rd_addr_o(rd_addr_o), .rd_data_o(rd_data_o),
        .halted_o(halted_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;  // 4 ns period
    end

    always @(posedge clk_i) begin
        if (retire_o) retire_cnt++;
    end

    task automatic flag_mismatch(input string msg);
        errors++;
        $display("FAILED t=%0t: %s", $time, msg);
    endtask

    task automatic load_word(input int k, input logic [31:0] word);
        logic granted;
        granted = 1'b0;
        @(negedge clk_i);
        load_req_i  = 1'b1;
        load_addr_i = 32'(k * 4);
        load_data_i = word;
        for (int w = 0; w < 4 && !granted; w++) begin
            @(posedge clk_i);
            granted = load_gnt_o;  // Write lands on this edge
        end
        if (!granted) begin
            errors++;
            $display("Loader word %0d was not granted within 4 cycles", k);
        end
    endtask

    task automatic check_retire(input int k);
        checks++;
        if (retire_pc_o !== exp_pc[k])
            flag_mismatch($sformatf("retire %0d pc %h, expected %h", k, retire_pc_o, exp_pc[k]));
        if (rd_wr_o !== exp_wr[k])
            flag_mismatch($sformatf("pc %h rd_wr %b, expected %b", exp_pc[k], rd_wr_o, exp_wr[k]));
        if (exp_wr[k] && rd_addr_o !== exp_rd[k])
            flag_mismatch($sformatf("pc %h rd x%0d, expected x%0d", exp_pc[k], rd_addr_o,
                                    exp_rd[k]));
        if (exp_wr[k] && rd_data_o !== exp_data[k])
            flag_mismatch($sformatf("pc %h rd_data %h, expected %h", exp_pc[k], rd_data_o,
                                    exp_data[k]));
    endtask

    initial begin
        int i;
        int held;
        reset_i     = 1'b1;
        run_i       = 1'b0;
        load_req_i  = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        build_program();
        built = 1'b1;
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);
        if (retire_o !== 1'b0 || halted_o !== 1'b0 || load_gnt_o !== 1'b0)
            flag_mismatch("outputs not idle after reset");
        for (i = 0; i < prog.size(); i++) begin
            load_word(i, prog[i]);
        end
        @(negedge clk_i);
        load_req_i = 1'b0;
        repeat (4) @(negedge clk_i);
        if (retire_cnt != 0 || halted_o !== 1'b0)
            flag_mismatch($sformatf("%0d retires or halt before run_i", retire_cnt));
        run_i = 1'b1;
        i = 0;
        while (i < exp_pc.size()) begin
            @(negedge clk_i);
            if (retire_o) begin
                check_retire(i);
                i++;
            end
        end
        while (halted_o !== 1'b1) @(negedge clk_i);
        // The illegal word itself must not retire
        if (retire_cnt != exp_pc.size())
            flag_mismatch($sformatf("%0d retires before halt, expected %0d", retire_cnt,
                                    exp_pc.size()));
        held = retire_cnt;
        repeat (20) @(negedge clk_i);
        if (retire_cnt != held || halted_o !== 1'b1)
            flag_mismatch($sformatf("%0d retires after halt", retire_cnt - held));
        $display("Summary: %0d retires checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Budget of 8 cycles per instruction plus loading and margin
    initial begin
        wait (built);
        #((8 * exp_pc.size() + 4 * prog.size() + 50) * 4);
        $display("Watchdog expired, the core hung after %0d of %0d retires",
                 retire_cnt, exp_pc.size());
        $display("Summary: %0d retires checked, %0d errors", checks, errors);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
